/* hdl/zx_kbd_settings.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes and bit positions for the ZX Spectrum keyboard adapter
// Include wherever the matrix or event word layout is needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ZX_KBD_SETTINGS_SVH
`define ZX_KBD_SETTINGS_SVH

// Spectrum key matrix
`define ZX_ROWS 8 // One row per address bit 15..8
`define ZX_COLS 5 // Data bits 4..0

// PS/2 side
`define PS2_CODE_W 8 // Set-2 scancode byte

// Event word from the PS/2 host, 11 bits
`define PS2_EVT_TOGGLE 10 // Inverted once per new event
`define PS2_EVT_PRESSED 9 // 1 on make, 0 on break
`define PS2_EVT_EXTENDED 8 // E0 prefixed code

`endif

/* hdl/zx_scancode_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types for the PS/2 side of the adapter
// Scancodes, function keys and modifier outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "zx_kbd_settings.svh"

package zx_scancode_pkg;

	// Set-2 codes handled by the decoder
	typedef enum logic [`PS2_CODE_W-1:0] {
		SC_F9 = 8'h01, SC_F5 = 8'h03, SC_F3 = 8'h04, SC_F1 = 8'h05,
		SC_F2 = 8'h06, SC_F10 = 8'h09, SC_F8 = 8'h0A, SC_F6 = 8'h0B,
		SC_F4 = 8'h0C, SC_ALT = 8'h11, SC_LSHIFT = 8'h12, SC_CTRL = 8'h14,
		SC_Q = 8'h15, SC_1 = 8'h16, SC_Z = 8'h1A, SC_S = 8'h1B,
		SC_A = 8'h1C, SC_W = 8'h1D, SC_2 = 8'h1E, SC_C = 8'h21,
		SC_X = 8'h22, SC_D = 8'h23, SC_E = 8'h24, SC_4 = 8'h25,
		SC_3 = 8'h26, SC_SPACE = 8'h29, SC_V = 8'h2A, SC_F = 8'h2B,
		SC_T = 8'h2C, SC_R = 8'h2D, SC_5 = 8'h2E, SC_N = 8'h31,
		SC_B = 8'h32, SC_H = 8'h33, SC_G = 8'h34, SC_Y = 8'h35,
		SC_6 = 8'h36, SC_M = 8'h3A, SC_J = 8'h3B, SC_U = 8'h3C,
		SC_7 = 8'h3D, SC_8 = 8'h3E, SC_COMMA = 8'h41, SC_K = 8'h42,
		SC_I = 8'h43, SC_O = 8'h44, SC_0 = 8'h45, SC_9 = 8'h46,
		SC_PERIOD = 8'h49, SC_L = 8'h4B, SC_P = 8'h4D, SC_MINUS = 8'h4E,
		SC_EQUALS = 8'h55, SC_CAPS = 8'h58, SC_RSHIFT = 8'h59, SC_ENTER = 8'h5A,
		SC_BKSP = 8'h66, SC_LEFT = 8'h6B, SC_DOWN = 8'h72, SC_RIGHT = 8'h74,
		SC_UP = 8'h75, SC_ESC = 8'h76, SC_F11 = 8'h78, SC_F7 = 8'h83
	} scancode_e;

	// F11..F1, active high, index matches the key number
	typedef logic [11:1] fn_keys_t;

	// Modifier outputs, msb first
	typedef struct packed {
		logic lctrl; // Bit 2
		logic alt; // Bit 1
		logic rshift; // Bit 0
	} mod_keys_t;

endpackage

`default_nettype wire

/* hdl/zx_matrix_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types for the Spectrum side of the adapter
// Matrix rows are active low, 0 means pressed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "zx_kbd_settings.svh"

package zx_matrix_pkg;

	// One half-row of keys as seen on data bits 4..0
	typedef logic [`ZX_COLS-1:0] zx_row_t;

	// Whole keyboard, row index = address bit minus 8
	typedef zx_row_t [`ZX_ROWS-1:0] zx_matrix_t;

	// Upper address byte, a 0 selects the row
	typedef logic [`ZX_ROWS-1:0] row_sel_t;

	// Shift keys live inside the matrix
	localparam int CS_ROW = 0; // CAPS SHIFT
	localparam int CS_COL = 0;
	localparam int SS_ROW = `ZX_ROWS - 1; // SYMBOL SHIFT
	localparam int SS_COL = 1;

	// Nothing pressed
	localparam zx_row_t ZX_ROW_IDLE = '1;

endpackage

`default_nettype wire

/* hdl/key_event_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One decoded key event, capture to decoder
// strobe is a single-cycle pulse, the rest valid with it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface key_event_if
	import zx_scancode_pkg::*;
();
	logic strobe; // New event this cycle
	logic pressed; // Make, else break
	logic extended; // E0 prefix seen
	scancode_e code;

	modport manager (
		output strobe, pressed, extended, code
	);

	modport worker (
		input strobe, pressed, extended, code
	);

endinterface

`default_nettype wire

/* hdl/ps2_event_capture.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Event capture from the PS/2 host word
// A change of the toggle bit gives one strobe and a registered event
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "zx_kbd_settings.svh"

module ps2_event_capture
	import zx_scancode_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic [`PS2_EVT_TOGGLE:0]  ps2_key,
	key_event_if.manager              evt
);

	logic toggle_q; // Toggle bit at the previous edge
	logic new_evt;

	assign new_evt = ps2_key[`PS2_EVT_TOGGLE] ^ toggle_q;

	// Toggle history also follows during reset, so leaving reset is quiet
	always_ff @(posedge clk_sys) begin
		toggle_q <= ps2_key[`PS2_EVT_TOGGLE];
		if (!rst_n) begin
			evt.strobe <= 1'b0;
		end else begin
			evt.strobe <= new_evt; // One cycle, source keeps 2-cycle spacing
		end
	end

	// Event payload
	always_ff @(posedge clk_sys) begin
		if (new_evt) begin
			evt.code     <= scancode_e'(ps2_key[`PS2_CODE_W-1:0]);
			evt.pressed  <= ps2_key[`PS2_EVT_PRESSED];
			evt.extended <= ps2_key[`PS2_EVT_EXTENDED];
		end
	end

endmodule

`default_nettype wire

/* hdl/key_matrix_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scancode to Spectrum matrix decoder
// Keeps the key matrix, F-key and modifier state from strobed events
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module key_matrix_decoder
	import zx_scancode_pkg::*;
	import zx_matrix_pkg::*;
(
	input  logic          clk_sys,
	input  logic          rst_n,
	key_event_if.worker   evt,
	output zx_matrix_t    matrix,
	output fn_keys_t      fn_keys,
	output mod_keys_t     mods
);

	logic left_shift; // Not reported on mods
	logic right_ctrl; // Ditto
	logic shift;
	logic ctrl;
	logic key_up; // Matrix level for the event key

	assign shift  = mods.rshift | left_shift;
	assign ctrl   = mods.lctrl | right_ctrl;
	assign key_up = ~evt.pressed;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			matrix     <= '1;
			fn_keys    <= '0;
			mods       <= '0;
			left_shift <= 1'b0;
			right_ctrl <= 1'b0;
		end else if (evt.strobe) begin
			// Modifiers and function keys
			case (evt.code)
				SC_RSHIFT: mods.rshift <= evt.pressed;
				SC_LSHIFT: left_shift  <= evt.pressed;
				SC_ALT:    mods.alt    <= evt.pressed;
				SC_CTRL: begin
					if (evt.extended)
						right_ctrl <= evt.pressed;
					else
						mods.lctrl <= evt.pressed;
				end
				SC_F1:  fn_keys[1]  <= evt.pressed;
				SC_F2:  fn_keys[2]  <= evt.pressed;
				SC_F3:  fn_keys[3]  <= evt.pressed;
				SC_F4:  fn_keys[4]  <= evt.pressed;
				SC_F5:  fn_keys[5]  <= evt.pressed;
				SC_F6:  fn_keys[6]  <= evt.pressed;
				SC_F7:  fn_keys[7]  <= evt.pressed;
				SC_F8:  fn_keys[8]  <= evt.pressed;
				SC_F9:  fn_keys[9]  <= evt.pressed;
				SC_F10: fn_keys[10] <= evt.pressed;
				SC_F11: fn_keys[11] <= evt.pressed;
				default: ;
			endcase

			// CAPS SHIFT and SYMBOL SHIFT
			if (evt.pressed) begin
				case (evt.code)
					SC_LEFT, SC_DOWN, SC_UP, SC_RIGHT, SC_BKSP, SC_CAPS, SC_ESC: begin
						matrix[CS_ROW][CS_COL] <= 1'b0; // Sent as CAPS combos
						matrix[SS_ROW][SS_COL] <= 1'b1;
					end
					SC_COMMA, SC_PERIOD, SC_MINUS, SC_EQUALS: begin
						matrix[SS_ROW][SS_COL] <= 1'b0; // Sent as SYMBOL combos
						matrix[CS_ROW][CS_COL] <= 1'b1;
					end
					SC_LSHIFT, SC_RSHIFT: begin
						matrix[CS_ROW][CS_COL] <= 1'b0;
						matrix[SS_ROW][SS_COL] <= ~ctrl;
					end
					SC_CTRL: begin
						matrix[SS_ROW][SS_COL] <= 1'b0;
						matrix[CS_ROW][CS_COL] <= ~shift;
					end
					default: begin
						matrix[CS_ROW][CS_COL] <= ~shift;
						matrix[SS_ROW][SS_COL] <= ~ctrl;
					end
				endcase
			end else begin
				// Only shift and ctrl releases touch them, so a cursor release
				// cannot drop CAPS SHIFT under a following cursor press
				case (evt.code)
					SC_LSHIFT: matrix[CS_ROW][CS_COL] <= ~mods.rshift;
					SC_RSHIFT: matrix[CS_ROW][CS_COL] <= ~left_shift;
					SC_CTRL: begin
						if (evt.extended)
							matrix[SS_ROW][SS_COL] <= ~mods.lctrl;
						else
							matrix[SS_ROW][SS_COL] <= ~right_ctrl;
					end
					default: ;
				endcase
			end

			// Plain keys
			case (evt.code)
				SC_Z: matrix[0][1] <= key_up;
				SC_X: matrix[0][2] <= key_up;
				SC_C: matrix[0][3] <= key_up;
				SC_V: matrix[0][4] <= key_up;
				SC_A: matrix[1][0] <= key_up;
				SC_S: matrix[1][1] <= key_up;
				SC_D: matrix[1][2] <= key_up;
				SC_F: matrix[1][3] <= key_up;
				SC_G: matrix[1][4] <= key_up;
				SC_Q: matrix[2][0] <= key_up;
				SC_W: matrix[2][1] <= key_up;
				SC_E: matrix[2][2] <= key_up;
				SC_R: matrix[2][3] <= key_up;
				SC_T: matrix[2][4] <= key_up;
				SC_1: matrix[3][0] <= key_up;
				SC_2, SC_CAPS: matrix[3][1] <= key_up; // Caps lock is CAPS 2
				SC_3: matrix[3][2] <= key_up;
				SC_4: matrix[3][3] <= key_up;
				SC_5, SC_LEFT: matrix[3][4] <= key_up; // Cursors are CAPS 5..8
				SC_0, SC_BKSP: matrix[4][0] <= key_up; // Delete is CAPS 0
				SC_9: matrix[4][1] <= key_up;
				SC_8, SC_RIGHT: matrix[4][2] <= key_up;
				SC_7, SC_UP: matrix[4][3] <= key_up;
				SC_6, SC_DOWN: matrix[4][4] <= key_up;
				SC_P: matrix[5][0] <= key_up;
				SC_O: matrix[5][1] <= key_up;
				SC_I: matrix[5][2] <= key_up;
				SC_U: matrix[5][3] <= key_up;
				SC_Y: matrix[5][4] <= key_up;
				SC_ENTER: matrix[6][0] <= key_up;
				SC_L: matrix[6][1] <= key_up;
				SC_K: matrix[6][2] <= key_up;
				SC_J: matrix[6][3] <= key_up;
				SC_H: matrix[6][4] <= key_up;
				SC_SPACE, SC_ESC: matrix[7][0] <= key_up; // Break is CAPS SPACE
				SC_M: matrix[7][2] <= key_up;
				SC_N: matrix[7][3] <= key_up;
				SC_B: matrix[7][4] <= key_up;
				// Punctuation, the shifted glyph sits on another key
				SC_COMMA: begin
					matrix[2][3] <= key_up | ~shift; // < on R
					matrix[7][3] <= key_up | shift; // , on N
				end
				SC_PERIOD: begin
					matrix[2][4] <= key_up | ~shift; // > on T
					matrix[7][2] <= key_up | shift; // . on M
				end
				SC_MINUS: begin
					matrix[4][0] <= key_up | ~shift; // _ on 0
					matrix[6][3] <= key_up | shift; // - on J
				end
				SC_EQUALS: begin
					matrix[6][2] <= key_up | ~shift; // + on K
					matrix[6][1] <= key_up | shift; // = on L
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/matrix_reader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Row readout for the ULA port
// Optional ghosting, then AND of all rows selected by the address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "zx_kbd_settings.svh"

module matrix_reader
	import zx_matrix_pkg::*;
(
	input  zx_matrix_t matrix,
	input  logic       ghosting,
	input  row_sel_t   row_sel,
	output zx_row_t    key_data
);

	zx_matrix_t ghosted; // Rows as the ULA would see them

	// Two rows share a pressed column when their OR has a 0 bit.
	// Only direct neighbours are merged, from the raw matrix, so the
	// effect does not chain through a third row
	always_comb begin
		for (int r = 0; r < `ZX_ROWS; r++) begin
			ghosted[r] = matrix[r];
			for (int o = 0; o < `ZX_ROWS; o++) begin
				if (ghosting && !(&(matrix[r] | matrix[o])))
					ghosted[r] &= matrix[o]; // Self merge is harmless
			end
		end
	end

	// Active-low rows, so selected rows combine by AND
	always_comb begin
		key_data = ZX_ROW_IDLE;
		for (int r = 0; r < `ZX_ROWS; r++) begin
			if (!row_sel[r])
				key_data &= ghosted[r];
		end
	end

endmodule

`default_nettype wire

/* hdl/zx_keyboard.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ZX Spectrum keyboard adapter, top level
// PS/2 events in, matrix row data for the upper address byte out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "zx_kbd_settings.svh"

module zx_keyboard
	import zx_scancode_pkg::*;
	import zx_matrix_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic [`PS2_EVT_TOGGLE:0]  ps2_key, // Toggle, pressed, extended, code
	input  logic                      ghosting, // Emulate real matrix ghosting
	input  logic [15:0]               addr, // Z80 address, high byte selects rows
	output zx_row_t                   key_data,
	output fn_keys_t                  fn_keys,
	output mod_keys_t                 mods
);

	key_event_if evt ();

	zx_matrix_t matrix; // Raw key state

	ps2_event_capture u_capture (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ps2_key (ps2_key),
		.evt     (evt.manager)
	);

	key_matrix_decoder u_decoder (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.evt     (evt.worker),
		.matrix  (matrix),
		.fn_keys (fn_keys),
		.mods    (mods)
	);

	matrix_reader u_reader (
		.matrix   (matrix),
		.ghosting (ghosting),
		.row_sel  (addr[15:8]), // A8 selects row 0
		.key_data (key_data)
	);

endmodule

`default_nettype wire

/* testbench/zx_keyboard_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Assertions on the keyboard adapter top level
// Attached to every zx_keyboard by the bind at the end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module zx_keyboard_checker
	import zx_scancode_pkg::*;
	import zx_matrix_pkg::*;
(
	input logic      clk_sys,
	input logic      rst_n,
	input logic [15:0] addr,
	input logic      strobe, // Capture to decoder pulse
	input zx_row_t   key_data,
	input fn_keys_t  fn_keys,
	input mod_keys_t mods
);

	// One event, one cycle
	strobe_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		strobe |=> !strobe)
		else $error("event strobe high for two cycles in a row");

	// Synchronous reset, values show one edge later
	reset_values: assert property (@(posedge clk_sys)
		!rst_n |=> (key_data == ZX_ROW_IDLE && fn_keys == '0 && mods == '0 && !strobe))
		else $error("outputs not at reset values during reset");

	// No row selected
	idle_readout: assert property (@(posedge clk_sys)
		(addr[15:8] == 8'hFF) |-> (key_data == ZX_ROW_IDLE))
		else $error("key_data not idle with no row selected");

endmodule

bind zx_keyboard zx_keyboard_checker u_checker (
	.clk_sys  (clk_sys),
	.rst_n    (rst_n),
	.addr     (addr),
	.strobe   (evt.strobe),
	.key_data (key_data),
	.fn_keys  (fn_keys),
	.mods     (mods)
);

`default_nettype wire

/* testbench/tb_zx_keyboard.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the ZX Spectrum keyboard adapter
// Random PS/2 events checked against a model of the key matrix
// Ends with $finish on success, $fatal on any failure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "zx_kbd_settings.svh"

module tb_zx_keyboard
	import zx_scancode_pkg::*;
	import zx_matrix_pkg::*;
();

	localparam int SEED = 46293;
	localparam int NUM_EVENTS = 2000;
	localparam int CLK_PERIOD = 100; // ns
	localparam int CYCLES_PER_EVENT = 4; // Toggle, latency, second readout
	localparam longint WATCHDOG_NS = longint'(NUM_EVENTS) * CYCLES_PER_EVENT * CLK_PERIOD + 2000;

	logic clk_sys;
	logic rst_n;
	logic [`PS2_EVT_TOGGLE:0] ps2_key;
	logic ghosting;
	logic [15:0] addr;
	zx_row_t key_data;
	fn_keys_t fn_keys;
	mod_keys_t mods;

	zx_matrix_t model_matrix; // Expected key state, active low
	fn_keys_t model_fn;
	mod_keys_t model_mods;
	logic model_lshift;
	logic model_rctrl;
	logic [31:0] rng_state;
	scancode_e all_codes[$]; // Every kept scancode

	// Spectrum layout, row 0 is A8 and column 0 is D0; CS and SS spots are placeholders
	scancode_e layout [`ZX_ROWS][`ZX_COLS] = '{
		'{SC_LSHIFT, SC_Z, SC_X, SC_C, SC_V},
		'{SC_A, SC_S, SC_D, SC_F, SC_G},
		'{SC_Q, SC_W, SC_E, SC_R, SC_T},
		'{SC_1, SC_2, SC_3, SC_4, SC_5},
		'{SC_0, SC_9, SC_8, SC_7, SC_6},
		'{SC_P, SC_O, SC_I, SC_U, SC_Y},
		'{SC_ENTER, SC_L, SC_K, SC_J, SC_H},
		'{SC_SPACE, SC_CTRL, SC_M, SC_N, SC_B}
	};
	scancode_e fn_codes [1:11] = '{SC_F1, SC_F2, SC_F3, SC_F4, SC_F5, SC_F6,
		SC_F7, SC_F8, SC_F9, SC_F10, SC_F11};
	scancode_e mod_codes [4] = '{SC_LSHIFT, SC_RSHIFT, SC_CTRL, SC_ALT};

	zx_keyboard uut (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.ps2_key  (ps2_key),
		.ghosting (ghosting),
		.addr     (addr),
		.key_data (key_data),
		.fn_keys  (fn_keys),
		.mods     (mods)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// Key whose matrix bit a CAPS combination key shares
	function automatic scancode_e alias_of(input scancode_e code);
		case (code)
			SC_LEFT:  return SC_5;
			SC_DOWN:  return SC_6;
			SC_UP:    return SC_7;
			SC_RIGHT: return SC_8;
			SC_BKSP:  return SC_0;
			SC_CAPS:  return SC_2;
			SC_ESC:   return SC_SPACE;
			default:  return code;
		endcase
	endfunction

	// Shifted glyph key in the high byte, plain glyph key in the low byte
	function automatic logic [15:0] punct_keys(input scancode_e code);
		case (code)
			SC_COMMA:  return {SC_R, SC_N}; // < and ,
			SC_PERIOD: return {SC_T, SC_M}; // > and .
			SC_MINUS:  return {SC_0, SC_J}; // _ and -
			SC_EQUALS: return {SC_K, SC_L}; // + and =
			default:   return '0;
		endcase
	endfunction

	task automatic set_key(input scancode_e key, input logic level);
		for (int r = 0; r < `ZX_ROWS; r++)
			for (int c = 0; c < `ZX_COLS; c++)
				if (layout[r][c] == key && !(r == CS_ROW && c == CS_COL)
						&& !(r == SS_ROW && c == SS_COL))
					model_matrix[r][c] = level;
	endtask

	task automatic set_caps_sym(input logic caps_n, input logic sym_n);
		model_matrix[CS_ROW][CS_COL] = caps_n;
		model_matrix[SS_ROW][SS_COL] = sym_n;
	endtask

	task automatic apply_event(input scancode_e code, input logic pressed, input logic ext);
		logic shift;
		logic ctrl;
		logic [15:0] punct;
		shift = model_mods.rshift | model_lshift; // State before this event
		ctrl = model_mods.lctrl | model_rctrl;
		punct = punct_keys(code);
		if (pressed) begin
			if (alias_of(code) != code)
				set_caps_sym(1'b0, 1'b1); // Cursors and friends
			else if (punct != '0)
				set_caps_sym(1'b1, 1'b0);
			else if (code == SC_LSHIFT || code == SC_RSHIFT)
				set_caps_sym(1'b0, ~ctrl);
			else if (code == SC_CTRL)
				set_caps_sym(~shift, 1'b0);
			else
				set_caps_sym(~shift, ~ctrl);
		end else if (code == SC_LSHIFT)
			model_matrix[CS_ROW][CS_COL] = ~model_mods.rshift; // Other shift decides
		else if (code == SC_RSHIFT)
			model_matrix[CS_ROW][CS_COL] = ~model_lshift;
		else if (code == SC_CTRL)
			model_matrix[SS_ROW][SS_COL] = ext ? ~model_mods.lctrl : ~model_rctrl;
		set_key(alias_of(code), ~pressed);
		if (punct != '0) begin
			set_key(scancode_e'(punct[15:8]), ~pressed | ~shift);
			set_key(scancode_e'(punct[7:0]), ~pressed | shift);
		end
		case (code)
			SC_RSHIFT: model_mods.rshift = pressed;
			SC_LSHIFT: model_lshift = pressed;
			SC_ALT:    model_mods.alt = pressed;
			SC_CTRL: begin
				if (ext)
					model_rctrl = pressed;
				else
					model_mods.lctrl = pressed;
			end
			default: ;
		endcase
		for (int k = 1; k <= 11; k++)
			if (code == fn_codes[k])
				model_fn[k] = pressed;
	endtask

	// Non-transitive ghosting, then AND of the selected rows
	function automatic zx_row_t expected_key_data(input row_sel_t sel, input logic ghost);
		zx_row_t row;
		zx_row_t data;
		data = '1;
		for (int r = 0; r < `ZX_ROWS; r++) begin
			row = model_matrix[r];
			for (int o = 0; o < `ZX_ROWS; o++)
				if (ghost && (model_matrix[r] | model_matrix[o]) != '1)
					row &= model_matrix[o];
			if (!sel[r])
				data &= row;
		end
		return data;
	endfunction

	task automatic stop_run(input string why);
		$display("Regression failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_row(input string name, input zx_row_t expected, input zx_row_t actual);
		if (actual !== expected) begin
			$display("FAIL t=%0t %s expected %b got %b", $time, name, expected, actual);
			stop_run("key row mismatch");
		end
	endtask

	task automatic check_fn(input fn_keys_t expected, input fn_keys_t actual);
		if (actual !== expected) begin
			$display("FAIL t=%0t fn_keys expected %b got %b", $time, expected, actual);
			stop_run("function key mismatch");
		end
	endtask

	task automatic check_mods(input mod_keys_t expected, input mod_keys_t actual);
		if (actual !== expected) begin
			$display("FAIL t=%0t mods expected %b got %b", $time, expected, actual);
			stop_run("modifier mismatch");
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the simulation hung before all events were checked");
		stop_run("watchdog timeout");
	end

	initial begin
		scancode_e code;
		logic pressed;
		logic ext;
		logic [31:0] r;
		rng_state = SEED;
		rst_n = 1'b0;
		ps2_key = '0;
		ghosting = 1'b0;
		addr = '1;
		model_matrix = '1;
		model_fn = '0;
		model_mods = '0;
		model_lshift = 1'b0;
		model_rctrl = 1'b0;
		code = code.first();
		do begin
			all_codes.push_back(code);
			code = code.next();
		end while (code != code.first());
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		addr = 16'h00FF; // All rows at once
		@(posedge clk_sys);
		check_row("key_data", ZX_ROW_IDLE, key_data);
		check_fn('0, fn_keys);
		check_mods('0, mods);
		for (int i = 0; i < NUM_EVENTS; i++) begin
			r = next_rand();
			if (r[1:0] == 2'd0)
				code = mod_codes[r[3:2]]; // Extra weight on shift and ctrl
			else
				code = all_codes[next_rand() % all_codes.size()];
			pressed = r[4] & r[7]; // Mostly releases, keeps the matrix sparse
			if (code == SC_CTRL)
				ext = r[5];
			else
				ext = code inside {SC_LEFT, SC_DOWN, SC_UP, SC_RIGHT};
			@(negedge clk_sys);
			ps2_key = {~ps2_key[`PS2_EVT_TOGGLE], pressed, ext, code};
			ghosting = r[6];
			if (r[9:8] == 2'd0)
				addr = {~(8'h01 << r[12:10]), r[31:24]}; // Single row
			else
				addr = {r[23:16], r[31:24]};
			apply_event(code, pressed, ext);
			repeat (3) @(posedge clk_sys);
			check_fn(model_fn, fn_keys);
			check_mods(model_mods, mods);
			check_row("key_data", expected_key_data(addr[15:8], ghosting), key_data);
			@(negedge clk_sys);
			ghosting = ~ghosting; // Same keys, other ghosting mode
			@(posedge clk_sys);
			check_row("key_data", expected_key_data(addr[15:8], ghosting), key_data);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
// Sources in compile order, packages first
+incdir+hdl
hdl/zx_scancode_pkg.sv
hdl/zx_matrix_pkg.sv
hdl/key_event_if.sv
hdl/ps2_event_capture.sv
hdl/key_matrix_decoder.sv
hdl/matrix_reader.sv
hdl/zx_keyboard.sv
testbench/zx_keyboard_checker.sv
testbench/tb_zx_keyboard.sv

/* run_sim.sh */
#!/bin/sh
# Builds the keyboard adapter testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero after any $fatal.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
	--top-module tb_zx_keyboard -Mdir obj_dir -o sim_zx_keyboard -f sim.f; then
	echo "Verilator build failed" >&2
	exit 1
fi

./obj_dir/sim_zx_keyboard
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status" >&2
fi
exit "$status"
